/* files.f */
+incdir+verilog
verilog/rvfi_check_pkg.sv
verilog/rvfi_delay_line.sv
verilog/rvfi_field_compare.sv
verilog/rvfi_check_regs.sv
verilog/rvfi_checker_top.sv
tests/rvfi_checker_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the RVFI checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rvfi_checker_tb \
  -f files.f

output=$(./obj_dir/Vrvfi_checker_tb)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

/* tests/rvfi_checker_tb.sv */
/*
 * Directed testbench for the RVFI retirement checker
 * Plays the reference model, sends core and reference records through
 * the checker and compares mismatch outputs and registers with
 * vectors worked out from the comparison rules
 */
`timescale 1ns/10ps
`include "rvfi_check_consts.svh"

module rvfi_checker_tb import rvfi_check_pkg::*; ();

  localparam int N_STREAM = 16;
  localparam int PAIR_CYC = 3;
  localparam int REG_CYC = 2;
  // Reset, record pairs of all tests, register accesses, margin
  localparam int N_PAIRS = N_STREAM + 6 + 7 + 2 + 4 + 3;
  localparam int N_REG = 32;
  localparam int MAX_CYCLES = 8 + PAIR_CYC * N_PAIRS + REG_CYC * N_REG + 50;

  localparam logic [31:0] CTRL_ARM = 32'd1 << `RVFI_CTRL_ARM;
  localparam logic [31:0] CTRL_STOP = 32'd1 << `RVFI_CTRL_STOP;
  localparam logic [31:0] CTRL_CLEAR = 32'd1 << `RVFI_CTRL_CLEAR;

  logic                        rvfi_core;
  logic                        reset_i;
  rvfi_rec_t                   core_rec_i;
  rvfi_rec_t                   rm_rec_i;
  cfg_req_t                    cfg_req_i;
  logic [`RVFI_XLEN-1:0]       cfg_rdata_o;
  logic                        mismatch_o;
  logic [`RVFI_NUM_FIELDS-1:0] mismatch_fields_o;
  logic                        stopped_o;

  int          checks = 0;
  int          errors = 0;
  int          tests = 0;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'h0caf6689;
  field_e      single_fields [6] = '{F_PC, F_INSN, F_TRAP, F_MODE, F_INTR, F_RD_ADDR};

  rvfi_checker_top dut_i (
    .rvfi_core        (rvfi_core),
    .reset_i          (reset_i),
    .core_rec_i       (core_rec_i),
    .rm_rec_i         (rm_rec_i),
    .cfg_req_i        (cfg_req_i),
    .cfg_rdata_o      (cfg_rdata_o),
    .mismatch_o       (mismatch_o),
    .mismatch_fields_o(mismatch_fields_o),
    .stopped_o        (stopped_o)
  );

  initial begin
    rvfi_core = 1'b0;
    forever #50 rvfi_core = ~rvfi_core;
  end

  always @(posedge rvfi_core) begin
    cycle_cnt++;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [`RVFI_NUM_FIELDS-1:0] field_bit(input field_e f);
    logic [`RVFI_NUM_FIELDS-1:0] v;
    v = '0;
    v[f] = 1'b1;
    return v;
  endfunction

  task automatic make_rec(output rvfi_rec_t r);
    logic [31:0] v;
    r = '0;
    r.valid = 1'b1;
    rand_bits(32, v);
    r.pc_rdata = v;
    rand_bits(32, v);
    r.insn = v;
    // Small control fields and masks from one draw
    rand_bits(21, v);
    r.trap = v[0];
    r.halt = v[1];
    r.dbg = v[4:2];
    r.mode = v[6:5];
    r.intr = v[7];
    r.rd1_addr = v[12:8];
    r.mem_rmask = v[16:13];
    r.mem_wmask = v[20:17];
    rand_bits(32, v);
    r.rd1_wdata = v;
    rand_bits(32, v);
    r.mem_addr = v;
    rand_bits(32, v);
    r.mem_rdata = v;
    rand_bits(32, v);
    r.mem_wdata = v;
  endtask

  // Reference copy with exactly one field changed
  task automatic alter_field(input rvfi_rec_t c, input field_e f, output rvfi_rec_t m);
    m = c;
    case (f)
      F_PC:      m.pc_rdata = ~c.pc_rdata;
      F_INSN:    m.insn = c.insn ^ 32'h0000_0100;
      F_TRAP:    m.trap = ~c.trap;
      F_MODE:    m.mode = c.mode ^ 2'b01;
      F_INTR:    m.intr = ~c.intr;
      F_RD_ADDR: m.rd1_addr = c.rd1_addr ^ 5'b00001;
      default:   m.valid = ~c.valid;
    endcase
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic next_cycle();
    @(posedge rvfi_core);
    #10;
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    next_cycle();
    cfg_req_i.we = 1'b1;
    cfg_req_i.addr = addr;
    cfg_req_i.wdata = data;
    next_cycle();
    cfg_req_i.we = 1'b0;
  endtask

  task automatic expect_reg(input reg_addr_e addr, input logic [31:0] exp, input string what);
    next_cycle();
    cfg_req_i.we = 1'b0;
    cfg_req_i.addr = addr;
    next_cycle();
    check_eq(what, cfg_rdata_o, exp);
  endtask

  // Core record first, reference one cycle later, result DELAY+1 edges on
  task automatic send_pair(input rvfi_rec_t core, input rvfi_rec_t rm,
                           input logic [`RVFI_NUM_FIELDS-1:0] exp, input string what);
    next_cycle();
    check_eq("mismatch_o before record", 32'(mismatch_o), 32'd0);
    core_rec_i = core;
    rm_rec_i = '0;
    next_cycle();
    check_eq("mismatch_o one edge early", 32'(mismatch_o), 32'd0);
    core_rec_i = '0;
    rm_rec_i = rm;
    next_cycle();
    rm_rec_i = '0;
    check_eq(what, 32'(mismatch_fields_o), 32'(exp));
    check_eq("mismatch_o", 32'(mismatch_o), 32'(|exp));
  endtask

  task automatic report_test(input string name, input int c0, input int e0);
    tests++;
    $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  task automatic test_matching_stream();
    rvfi_rec_t r;
    int c0 = checks;
    int e0 = errors;
    check_eq("mismatch_o after reset", 32'(mismatch_o), 32'd0);
    check_eq("stopped_o after reset", 32'(stopped_o), 32'd0);
    expect_reg(REG_STATUS, {30'd0, CHK_IDLE}, "status after reset");
    expect_reg(REG_FIELD_EN, 32'h0000_3fff, "field enables after reset");
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    for (int i = 0; i < N_STREAM; i++) begin
      make_rec(r);
      send_pair(r, r, '0, "identical records");
    end
    expect_reg(REG_MATCH_COUNT, N_STREAM, "match count");
    expect_reg(REG_ERR_COUNT, 32'd0, "error count");
    report_test("matching stream", c0, e0);
  endtask

  task automatic test_single_fields();
    rvfi_rec_t c;
    rvfi_rec_t m;
    logic [31:0] first_pc;
    int c0 = checks;
    int e0 = errors;
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    for (int k = 0; k < 6; k++) begin
      make_rec(c);
      alter_field(c, single_fields[k], m);
      if (k == 0) begin
        first_pc = m.pc_rdata;
      end
      send_pair(c, m, field_bit(single_fields[k]), "single field mismatch");
    end
    expect_reg(REG_ERR_COUNT, 32'd6, "error count");
    expect_reg(REG_FIRST_PC, first_pc, "first failing pc");
    expect_reg(REG_FIRST_FIELDS, 32'(field_bit(F_PC)), "first failing fields");
    report_test("single field mismatches", c0, e0);
  endtask

  task automatic test_conditional_fields();
    rvfi_rec_t c;
    rvfi_rec_t m;
    int c0 = checks;
    int e0 = errors;
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    make_rec(c);
    c.rd1_addr = 5'd0;
    m = c;
    m.rd1_wdata = ~c.rd1_wdata;
    send_pair(c, m, '0, "rd1_wdata to x0");
    c.rd1_addr = 5'd7;
    m = c;
    m.rd1_wdata = ~c.rd1_wdata;
    send_pair(c, m, field_bit(F_RD_WDATA), "rd1_wdata to x7");
    // Read of the two low bytes
    make_rec(c);
    c.mem_rmask = 4'b0011;
    c.mem_wmask = 4'b0000;
    m = c;
    m.mem_rdata[31:24] = ~c.mem_rdata[31:24];
    send_pair(c, m, '0, "rdata byte outside mask");
    m = c;
    m.mem_rdata[7:0] = ~c.mem_rdata[7:0];
    send_pair(c, m, field_bit(F_MEM_RDATA), "rdata byte inside mask");
    // Write of byte 2 only
    c.mem_rmask = 4'b0000;
    c.mem_wmask = 4'b0100;
    m = c;
    m.mem_wdata[7:0] = ~c.mem_wdata[7:0];
    send_pair(c, m, '0, "wdata byte outside mask");
    m = c;
    m.mem_wdata[23:16] = ~c.mem_wdata[23:16];
    send_pair(c, m, field_bit(F_MEM_WDATA), "wdata byte inside mask");
    c.mem_wmask = 4'b0000;
    m = c;
    m.mem_addr = ~c.mem_addr;
    send_pair(c, m, '0, "mem_addr without access");
    expect_reg(REG_ERR_COUNT, 32'd3, "error count");
    report_test("conditional fields", c0, e0);
  endtask

  task automatic test_valid_skew();
    rvfi_rec_t c;
    rvfi_rec_t m;
    int c0 = checks;
    int e0 = errors;
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    make_rec(c);
    m = c;
    m.valid = 1'b0;
    send_pair(c, m, field_bit(F_VALID), "core without reference");
    make_rec(m);
    c = m;
    c.valid = 1'b0;
    send_pair(c, m, field_bit(F_VALID), "reference without core");
    report_test("valid skew", c0, e0);
  endtask

  task automatic test_enables_and_idle();
    rvfi_rec_t c;
    rvfi_rec_t m;
    logic [`RVFI_NUM_FIELDS-1:0] en;
    int c0 = checks;
    int e0 = errors;
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    en = ~field_bit(F_PC);
    write_reg(REG_FIELD_EN, 32'(en));
    make_rec(c);
    alter_field(c, F_PC, m);
    send_pair(c, m, '0, "disabled pc field");
    alter_field(c, F_INSN, m);
    send_pair(c, m, field_bit(F_INSN), "enabled insn field");
    write_reg(REG_FIELD_EN, 32'h0000_3fff);
    // Disarmed checker compares and counts nothing
    write_reg(REG_CTRL, 32'd0);
    expect_reg(REG_STATUS, {30'd0, CHK_IDLE}, "status when idle");
    send_pair(c, m, '0, "insn mismatch while idle");
    m.valid = 1'b0;
    send_pair(c, m, '0, "valid skew while idle");
    expect_reg(REG_ERR_COUNT, 32'd1, "error count after idle");
    expect_reg(REG_MATCH_COUNT, 32'd1, "match count after idle");
    report_test("field enables and idle", c0, e0);
  endtask

  task automatic test_stop_and_clear();
    rvfi_rec_t c;
    rvfi_rec_t m;
    rvfi_rec_t c2;
    rvfi_rec_t m2;
    int c0 = checks;
    int e0 = errors;
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_STOP | CTRL_ARM);
    make_rec(c);
    alter_field(c, F_TRAP, m);
    make_rec(c2);
    alter_field(c2, F_INSN, m2);
    // Two failing records back to back, the second right behind the first
    next_cycle();
    core_rec_i = c;
    next_cycle();
    core_rec_i = c2;
    rm_rec_i = m;
    next_cycle();
    core_rec_i = '0;
    rm_rec_i = m2;
    check_eq("first error", 32'(mismatch_fields_o), 32'(field_bit(F_TRAP)));
    next_cycle();
    rm_rec_i = '0;
    check_eq("mismatch_o for record behind first error", 32'(mismatch_o), 32'd0);
    check_eq("stopped_o after first error", 32'(stopped_o), 32'd1);
    expect_reg(REG_STATUS, {30'd0, CHK_STOPPED}, "status when stopped");
    alter_field(c, F_INSN, m);
    send_pair(c, m, '0, "insn mismatch after stop");
    alter_field(c, F_PC, m);
    send_pair(c, m, '0, "pc mismatch after stop");
    expect_reg(REG_ERR_COUNT, 32'd1, "error count after stop");
    write_reg(REG_CTRL, CTRL_CLEAR | CTRL_ARM);
    check_eq("stopped_o after rearm", 32'(stopped_o), 32'd0);
    expect_reg(REG_ERR_COUNT, 32'd0, "error count after clear");
    expect_reg(REG_STATUS, {30'd0, CHK_ARMED}, "status after rearm");
    report_test("stop on error and clear", c0, e0);
  endtask

  initial begin
    core_rec_i = '0;
    rm_rec_i = '0;
    cfg_req_i = '0;
    reset_i = 1'b1;
    repeat (8) @(posedge rvfi_core);
    #10;
    reset_i = 1'b0;
    test_matching_stream();
    test_single_fields();
    test_conditional_fields();
    test_valid_skew();
    test_enables_and_idle();
    test_stop_and_clear();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* verilog/rvfi_check_consts.svh */
/*
 * RVFI retirement checker constants
 * Widths, alignment depth, field count, register map addresses and
 * control register bit positions
 */
`ifndef RVFI_CHECK_CONSTS_SVH
`define RVFI_CHECK_CONSTS_SVH

`define RVFI_XLEN         32
`define RVFI_ALIGN_DELAY  1
`define RVFI_NUM_FIELDS   14
`define RVFI_CNT_W        16

// Register map
`define RVFI_REG_AW       3
`define RVFI_REG_CTRL         3'd0
`define RVFI_REG_FIELD_EN     3'd1
`define RVFI_REG_STATUS       3'd2
`define RVFI_REG_ERR_COUNT    3'd3
`define RVFI_REG_MATCH_COUNT  3'd4
`define RVFI_REG_FIRST_PC     3'd5
`define RVFI_REG_FIRST_FIELDS 3'd6

// Bits of REG_CTRL
`define RVFI_CTRL_ARM     0
`define RVFI_CTRL_STOP    1
`define RVFI_CTRL_CLEAR   2

`endif

/* verilog/rvfi_check_pkg.sv */
/*
 * RVFI retirement checker types
 * Retirement record, configuration access, checker states,
 * field bit positions and register addresses
 */
package rvfi_check_pkg;

  `include "rvfi_check_consts.svh"

  // One retired instruction as seen on RVFI
  typedef struct packed {
    logic                      valid;
    logic [`RVFI_XLEN-1:0]     pc_rdata;
    logic [`RVFI_XLEN-1:0]     insn;
    logic                      trap;
    logic                      halt;
    logic [2:0]                dbg;
    logic [1:0]                mode;
    logic                      intr;
    logic [4:0]                rd1_addr;
    logic [`RVFI_XLEN-1:0]     rd1_wdata;
    logic [`RVFI_XLEN-1:0]     mem_addr;
    logic [`RVFI_XLEN/8-1:0]   mem_rmask;
    logic [`RVFI_XLEN/8-1:0]   mem_wmask;
    logic [`RVFI_XLEN-1:0]     mem_rdata;
    logic [`RVFI_XLEN-1:0]     mem_wdata;
  } rvfi_rec_t;

  typedef enum logic [`RVFI_REG_AW-1:0] {
    REG_CTRL         = `RVFI_REG_CTRL,
    REG_FIELD_EN     = `RVFI_REG_FIELD_EN,
    REG_STATUS       = `RVFI_REG_STATUS,
    REG_ERR_COUNT    = `RVFI_REG_ERR_COUNT,
    REG_MATCH_COUNT  = `RVFI_REG_MATCH_COUNT,
    REG_FIRST_PC     = `RVFI_REG_FIRST_PC,
    REG_FIRST_FIELDS = `RVFI_REG_FIRST_FIELDS
  } reg_addr_e;

  typedef struct packed {
    logic                  we;
    reg_addr_e             addr;
    logic [`RVFI_XLEN-1:0] wdata;
  } cfg_req_t;

  // Bit positions in the enable and mismatch vectors
  typedef enum logic [3:0] {
    F_VALID, F_PC, F_INSN, F_TRAP,
    F_HALT, F_DBG, F_MODE, F_INTR,
    F_RD_ADDR, F_RD_WDATA, F_MEM_MASK,
    F_MEM_ADDR, F_MEM_WDATA, F_MEM_RDATA
  } field_e;

  typedef enum logic [1:0] {
    CHK_IDLE    = 2'd0,
    CHK_ARMED   = 2'd1,
    CHK_STOPPED = 2'd2
  } chk_state_e;

endpackage

/* verilog/rvfi_check_regs.sv */
/*
 * Checker control and status registers
 * Holds the arm / stop FSM, field enables, saturating mismatch and
 * match counters and the first failing PC and field vector
 */
`timescale 1ns/10ps
`include "rvfi_check_consts.svh"

module rvfi_check_regs import rvfi_check_pkg::*; (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  input  cfg_req_t                    cfg_req_i,
  output logic [`RVFI_XLEN-1:0]       cfg_rdata_o,
  input  logic [`RVFI_NUM_FIELDS-1:0] mismatch_i,
  input  logic                        compared_i,
  input  logic [`RVFI_XLEN-1:0]       pc_i,
  output logic                        check_en_o,
  output logic [`RVFI_NUM_FIELDS-1:0] field_en_o,
  output logic                        stopped_o
);

  chk_state_e                  state_q;
  logic                        stop_on_err_q;
  logic [`RVFI_NUM_FIELDS-1:0] field_en_q;
  logic [`RVFI_CNT_W-1:0]      err_cnt_q;
  logic [`RVFI_CNT_W-1:0]      match_cnt_q;
  logic                        first_seen_q;
  logic [`RVFI_XLEN-1:0]       first_pc_q;
  logic [`RVFI_NUM_FIELDS-1:0] first_fields_q;

  logic ctrl_wr;
  logic clr;
  logic any_mis;
  logic stop_now;

  assign ctrl_wr  = cfg_req_i.we && (cfg_req_i.addr == REG_CTRL);
  assign clr      = ctrl_wr && cfg_req_i.wdata[`RVFI_CTRL_CLEAR];
  assign any_mis  = |mismatch_i;
  assign stop_now = (state_q == CHK_ARMED) && stop_on_err_q && any_mis;

  // Gate the stopping edge too, so the record behind the failure is skipped
  assign check_en_o = (state_q == CHK_ARMED) && !stop_now;
  assign field_en_o = field_en_q;
  assign stopped_o  = (state_q == CHK_STOPPED);

  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      state_q       <= CHK_IDLE;
      stop_on_err_q <= 1'b0;
      field_en_q    <= '1;
    end else begin
      if (ctrl_wr) begin
        state_q       <= cfg_req_i.wdata[`RVFI_CTRL_ARM] ? CHK_ARMED : CHK_IDLE;
        stop_on_err_q <= cfg_req_i.wdata[`RVFI_CTRL_STOP];
      end else if (stop_now) begin
        state_q <= CHK_STOPPED;
      end
      if (cfg_req_i.we && cfg_req_i.addr == REG_FIELD_EN) begin
        field_en_q <= cfg_req_i.wdata[`RVFI_NUM_FIELDS-1:0];
      end
    end
  end

  // Counters saturate, clear wins over a same-cycle update
  always_ff @(posedge rvfi_core) begin
    if (reset_i || clr) begin
      err_cnt_q    <= '0;
      match_cnt_q  <= '0;
      first_seen_q <= 1'b0;
    end else if (compared_i) begin
      if (any_mis) begin
        if (err_cnt_q != '1) begin
          err_cnt_q <= err_cnt_q + 1'b1;
        end
        first_seen_q <= 1'b1;
      end else if (match_cnt_q != '1) begin
        match_cnt_q <= match_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge rvfi_core) begin
    if (compared_i && any_mis && !first_seen_q) begin
      first_pc_q     <= pc_i;
      first_fields_q <= mismatch_i;
    end
  end

  // Registered read of whatever address is presented
  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      cfg_rdata_o <= '0;
    end else begin
      cfg_rdata_o <= '0;
      case (cfg_req_i.addr)
        REG_CTRL:         cfg_rdata_o[1:0] <= {stop_on_err_q, state_q == CHK_ARMED};
        REG_FIELD_EN:     cfg_rdata_o[`RVFI_NUM_FIELDS-1:0] <= field_en_q;
        REG_STATUS:       cfg_rdata_o[1:0] <= state_q;
        REG_ERR_COUNT:    cfg_rdata_o[`RVFI_CNT_W-1:0] <= err_cnt_q;
        REG_MATCH_COUNT:  cfg_rdata_o[`RVFI_CNT_W-1:0] <= match_cnt_q;
        REG_FIRST_PC:     cfg_rdata_o <= first_seen_q ? first_pc_q : '0;
        REG_FIRST_FIELDS: begin
          if (first_seen_q) begin
            cfg_rdata_o[`RVFI_NUM_FIELDS-1:0] <= first_fields_q;
          end
        end
        default:          cfg_rdata_o <= '0;
      endcase
    end
  end

  err_cnt_mono_a: assert property (@(posedge rvfi_core) disable iff (reset_i)
    (!$past(reset_i) && !$past(clr)) |-> (err_cnt_q >= $past(err_cnt_q)));

endmodule

/* verilog/rvfi_checker_top.sv */
/*
 * RVFI retirement checker top level
 * Aligns the core trace to the reference model, compares them
 * field by field and exposes the configuration registers
 */
`timescale 1ns/10ps
`include "rvfi_check_consts.svh"

module rvfi_checker_top import rvfi_check_pkg::*; (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  input  rvfi_rec_t                   core_rec_i,
  input  rvfi_rec_t                   rm_rec_i,
  input  cfg_req_t                    cfg_req_i,
  output logic [`RVFI_XLEN-1:0]       cfg_rdata_o,
  output logic                        mismatch_o,
  output logic [`RVFI_NUM_FIELDS-1:0] mismatch_fields_o,
  output logic                        stopped_o
);

  rvfi_rec_t                   core_aligned;
  logic                        check_en;
  logic [`RVFI_NUM_FIELDS-1:0] field_en;
  logic                        compared;
  logic [`RVFI_XLEN-1:0]       cmp_pc;

  rvfi_delay_line #(
    .DEPTH(`RVFI_ALIGN_DELAY)
  ) delay_i (
    .rvfi_core(rvfi_core),
    .reset_i  (reset_i),
    .rec_i    (core_rec_i),
    .rec_o    (core_aligned)
  );

  rvfi_field_compare compare_i (
    .rvfi_core (rvfi_core),
    .reset_i   (reset_i),
    .core_rec_i(core_aligned),
    .rm_rec_i  (rm_rec_i),
    .check_en_i(check_en),
    .field_en_i(field_en),
    .mismatch_o(mismatch_fields_o),
    .compared_o(compared),
    .pc_o      (cmp_pc)
  );

  // Any field failing flags the record
  assign mismatch_o = |mismatch_fields_o;

  rvfi_check_regs regs_i (
    .rvfi_core  (rvfi_core),
    .reset_i    (reset_i),
    .cfg_req_i  (cfg_req_i),
    .cfg_rdata_o(cfg_rdata_o),
    .mismatch_i (mismatch_fields_o),
    .compared_i (compared),
    .pc_i       (cmp_pc),
    .check_en_o (check_en),
    .field_en_o (field_en),
    .stopped_o  (stopped_o)
  );

endmodule

/* verilog/rvfi_delay_line.sv */
/*
 * Alignment delay for the core retirement stream
 * Shifts core records through DEPTH stages so they meet the
 * reference model records, which retire later
 */
`timescale 1ns/10ps
`include "rvfi_check_consts.svh"

module rvfi_delay_line import rvfi_check_pkg::*; #(
  parameter int DEPTH = `RVFI_ALIGN_DELAY
) (
  input  logic      rvfi_core,
  input  logic      reset_i,
  input  rvfi_rec_t rec_i,
  output rvfi_rec_t rec_o
);

  logic [DEPTH-1:0] valid_q;
  rvfi_rec_t        rec_q [DEPTH];

  // Payload chain
  always_ff @(posedge rvfi_core) begin
    rec_q[0] <= rec_i;
    for (int i = 1; i < DEPTH; i++) begin
      rec_q[i] <= rec_q[i-1];
    end
  end

  // Valid bits only, so reset flushes the chain
  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= rec_i.valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_comb begin
    rec_o       = rec_q[DEPTH-1];
    rec_o.valid = valid_q[DEPTH-1];
  end

  // Whatever leaves valid entered intact DEPTH cycles before
  delay_a: assert property (@(posedge rvfi_core) disable iff (reset_i)
    rec_o.valid |-> (rec_o == $past(rec_i, DEPTH)));

endmodule

/* verilog/rvfi_field_compare.sv */
/*
 * RVFI field comparator
 * Compares an aligned core record with the reference record under
 * the per-field mask rules and registers the mismatch vector, a
 * compared strobe and the reference PC
 */
`timescale 1ns/10ps
`include "rvfi_check_consts.svh"

module rvfi_field_compare import rvfi_check_pkg::*; (
  input  logic                        rvfi_core,
  input  logic                        reset_i,
  input  rvfi_rec_t                   core_rec_i,
  input  rvfi_rec_t                   rm_rec_i,
  input  logic                        check_en_i,
  input  logic [`RVFI_NUM_FIELDS-1:0] field_en_i,
  output logic [`RVFI_NUM_FIELDS-1:0] mismatch_o,
  output logic                        compared_o,
  output logic [`RVFI_XLEN-1:0]       pc_o
);

  logic [`RVFI_NUM_FIELDS-1:0] raw_mis;
  logic [`RVFI_NUM_FIELDS-1:0] mis_d;
  logic                        any_valid;
  logic                        rm_v;
  logic                        mem_access;
  logic                        wdata_diff;
  logic                        rdata_diff;

  assign any_valid  = core_rec_i.valid | rm_rec_i.valid;
  assign rm_v       = rm_rec_i.valid;
  assign mem_access = |{core_rec_i.mem_rmask, core_rec_i.mem_wmask};

  // Byte lanes only count where the core says an access happened
  always_comb begin
    wdata_diff = 1'b0;
    rdata_diff = 1'b0;
    for (int b = 0; b < `RVFI_XLEN/8; b++) begin
      if (core_rec_i.mem_wmask[b] &&
          core_rec_i.mem_wdata[8*b +: 8] != rm_rec_i.mem_wdata[8*b +: 8]) begin
        wdata_diff = 1'b1;
      end
      if (core_rec_i.mem_rmask[b] &&
          core_rec_i.mem_rdata[8*b +: 8] != rm_rec_i.mem_rdata[8*b +: 8]) begin
        rdata_diff = 1'b1;
      end
    end
  end

  always_comb begin
    raw_mis = '0;
    raw_mis[F_VALID]     = any_valid && (core_rec_i.valid != rm_rec_i.valid);
    raw_mis[F_PC]        = rm_v && (core_rec_i.pc_rdata != rm_rec_i.pc_rdata);
    raw_mis[F_INSN]      = rm_v && (core_rec_i.insn != rm_rec_i.insn);
    raw_mis[F_TRAP]      = rm_v && (core_rec_i.trap != rm_rec_i.trap);
    raw_mis[F_HALT]      = rm_v && (core_rec_i.halt != rm_rec_i.halt);
    raw_mis[F_DBG]       = rm_v && (core_rec_i.dbg != rm_rec_i.dbg);
    raw_mis[F_MODE]      = rm_v && (core_rec_i.mode != rm_rec_i.mode);
    raw_mis[F_INTR]      = rm_v && (core_rec_i.intr != rm_rec_i.intr);
    raw_mis[F_RD_ADDR]   = rm_v && (core_rec_i.rd1_addr != rm_rec_i.rd1_addr);
    // x0 writes are architecturally invisible
    raw_mis[F_RD_WDATA]  = rm_v && (rm_rec_i.rd1_addr != 5'd0) &&
                           (core_rec_i.rd1_wdata != rm_rec_i.rd1_wdata);
    raw_mis[F_MEM_MASK]  = rm_v && ((core_rec_i.mem_rmask != rm_rec_i.mem_rmask) ||
                                    (core_rec_i.mem_wmask != rm_rec_i.mem_wmask));
    raw_mis[F_MEM_ADDR]  = rm_v && mem_access &&
                           (core_rec_i.mem_addr != rm_rec_i.mem_addr);
    raw_mis[F_MEM_WDATA] = rm_v && wdata_diff;
    raw_mis[F_MEM_RDATA] = rm_v && rdata_diff;
  end

  assign mis_d = raw_mis & field_en_i & {`RVFI_NUM_FIELDS{check_en_i}};

  always_ff @(posedge rvfi_core) begin
    if (reset_i) begin
      mismatch_o <= '0;
      compared_o <= 1'b0;
    end else begin
      mismatch_o <= mis_d;
      compared_o <= check_en_i && any_valid;
    end
  end

  // Reference PC for first-failure capture
  always_ff @(posedge rvfi_core) begin
    pc_o <= rm_rec_i.pc_rdata;
  end

  mis_needs_cmp_a: assert property (@(posedge rvfi_core) disable iff (reset_i)
    |mismatch_o |-> compared_o);

  mis_field_en_a: assert property (@(posedge rvfi_core) disable iff (reset_i)
    (mismatch_o & ~$past(field_en_i)) == '0);

endmodule
